//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_hdc_core
FILELIST = verilog.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) design/hdc_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/hdc_core.sv
module hdc_core
    import hdc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       run,
    input  logic       gen,
    input  logic       update_item,
    input  item_addr_t item_a,
    input  hv_t        rand_num,
    input  logic       get_v,
    input  hdc_inst_u  get_d,
    input  logic       exec,
    input  hv_t        sign_bit,
    output logic       store,
    output logic       last,
    output hv_t        core_result
);

    item_addr_t rd_addr;
    wb_req_t    wb_req;
    hdc_op_t    op;
    hv_t        ld_vec;

    // r2 goes back to memory as write-back data
    hv_t        r2;

    hdc_item_memory hdc_item_memory_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .gen         (gen),
        .update_item (update_item),
        .item_a      (item_a),
        .rand_num    (rand_num),
        .wb_req      (wb_req),
        .wb_data     (r2),
        .rd_addr     (rd_addr),
        .ld_vec      (ld_vec)
    );

    hdc_inst_decoder hdc_inst_decoder_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .get_v   (get_v),
        .get_d   (get_d),
        .rd_addr (rd_addr),
        .wb_req  (wb_req),
        .op      (op)
    );

    hdc_vector_unit hdc_vector_unit_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .exec        (exec),
        .op          (op),
        .ld_vec      (ld_vec),
        .sign_bit    (sign_bit),
        .r2          (r2),
        .store       (store),
        .last        (last),
        .core_result (core_result)
    );

endmodule

//--- design/hdc_defs.svh
`ifndef HDC_DEFS_SVH
`define HDC_DEFS_SVH

// hypervector width in bits
`define HDC_VEC_W 1024

// item memory address width
`define HDC_ADDR_W 10

// number of stored hypervectors
`define HDC_DEPTH 1024

// instruction word width
`define HDC_INST_W 16

// instruction layout, for reference when reading the package
//   bit 15      class, set when the word carries an item address
//   bit 14      load (address class) or right rotate (op class)
//   bit 13      write-back (address class) or left rotate (op class)
//   bits 12:3   one-hot rotate amount or op select
//   bits 9:0    item address (address class)
// write-back is the one word that sets both 15 and 13
// rotate amount runs from 1 at bit 12 up to 512 at bit 3
// the op select bits are xor, store, last, move, sign-load from bit 12 down

`endif

//--- design/hdc_inst_decoder.sv
module hdc_inst_decoder
    import hdc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       get_v,
    input  hdc_inst_u  get_d,
    output item_addr_t rd_addr,
    output wb_req_t    wb_req,
    output hdc_op_t    op
);

    // address class with the write-back bit
    logic is_wb;

    assign is_wb = get_d.mem.cls[1] && get_d.mem.wb;

    // memory read starts on the same edge the word is accepted,
    // so the address goes out unregistered
    assign rd_addr = get_d.mem.addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_req <= '0;
            op     <= '0;
        end else if (get_v) begin
            if (is_wb) begin
                // write-back only touches memory, vector unit idles
                wb_req.valid <= 1'b1;
                wb_req.addr  <= get_d.mem.addr;
                op           <= '0;
            end else begin
                wb_req   <= '0;
                op.inst  <= get_d;
            end
        end else begin
            // nothing accepted gives a nop for one cycle
            wb_req <= '0;
            op     <= '0;
        end
    end

    // a write-back must not also run an op on r2 that cycle,
    // otherwise forwarding in the memory would return a stale r2
    a_wb_with_nop: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_req.valid |-> (op == '0)
    );

endmodule

//--- design/hdc_item_memory.sv
`include "hdc_defs.svh"

module hdc_item_memory
    import hdc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       gen,
    input  logic       update_item,
    input  item_addr_t item_a,
    input  hv_t        rand_num,
    input  wb_req_t    wb_req,
    input  hv_t        wb_data,
    input  item_addr_t rd_addr,
    output hv_t        ld_vec
);

    // block ram, one hypervector per entry
    hv_t mem [`HDC_DEPTH];

    // registered read data
    hv_t rd_q;

    // write-back to the address being read on the same edge
    logic fwd_q;

    logic fill_en;

    assign fill_en = gen && update_item;

    // single write port, write-back wins over a random fill
    // read is issued every cycle whether or not it is needed
    always_ff @(posedge clk) begin
        if (wb_req.valid) begin
            mem[wb_req.addr] <= wb_data;
        end else if (fill_en) begin
            mem[item_a] <= rand_num;
        end
        rd_q <= mem[rd_addr];
    end

    // the ram returns old data when a write-back lands on the read
    // address, so remember that and take r2 straight from the unit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_q <= 1'b0;
        end else begin
            fwd_q <= wb_req.valid && (wb_req.addr == rd_addr);
        end
    end

    // r2 has not moved since the write-back, as the write-back op is a nop
    assign ld_vec = fwd_q ? wb_data : rd_q;

    // decoder must never request a write-back to an undefined entry
    a_wb_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_req.valid |-> !$isunknown(wb_req.addr)
    );

endmodule

//--- design/hdc_pkg.sv
`include "hdc_defs.svh"

package hdc_pkg;

    // one hypervector
    typedef logic [`HDC_VEC_W-1:0] hv_t;

    // item memory address
    typedef logic [`HDC_ADDR_W-1:0] item_addr_t;

    // memory view of an instruction
    // cls[1] says an address follows, cls[0] is load
    typedef struct packed {
        logic [1:0]                            cls;
        logic                                  wb;
        logic [`HDC_INST_W-`HDC_ADDR_W-4:0]    spare;
        item_addr_t                            addr;
    } mem_view_t;

    // op view of an instruction
    // with rot_r or rot_l set, sel is the one-hot rotate amount
    // otherwise sel[9] xor, sel[8] store, sel[7] last, sel[6] move,
    // sel[5] sign-load
    typedef struct packed {
        logic                                  cls;
        logic                                  rot_r;
        logic                                  rot_l;
        logic [9:0]                            sel;
        logic [`HDC_INST_W-14:0]               spare;
    } op_view_t;

    // same 16 bits, decoded either way depending on class
    typedef union packed {
        mem_view_t mem;
        op_view_t  op;
    } hdc_inst_u;

    // pending write-back of r2 into the item memory
    typedef struct packed {
        logic       valid;
        item_addr_t addr;
    } wb_req_t;

    // registered instruction handed to the vector unit
    // all zero is a nop
    typedef struct packed {
        hdc_inst_u inst;
    } hdc_op_t;

endpackage

//--- design/hdc_vector_unit.sv
`include "hdc_defs.svh"

module hdc_vector_unit
    import hdc_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    run,
    input  logic    exec,
    input  hdc_op_t op,
    input  hv_t     ld_vec,
    input  hv_t     sign_bit,
    output hv_t     r2,
    output logic    store,
    output logic    last,
    output hv_t     core_result
);

    // one-hot rotate amounts run from 1 up to 512
    localparam int ROT_STEPS = 10;

    hv_t r1;

    // rotate distance is zero when no amount bit is set
    logic [ROT_STEPS-1:0] rot_n;

    hv_t rot_r_vec;
    hv_t rot_l_vec;

    // op fields
    logic       is_addr;
    logic       is_load;
    logic       rot_r;
    logic       rot_l;
    logic [9:0] sel;

    assign is_addr = op.inst.mem.cls[1];
    assign is_load = op.inst.mem.cls[0];
    assign rot_r   = op.inst.op.rot_r;
    assign rot_l   = op.inst.op.rot_l;
    assign sel     = op.inst.op.sel;

    // sel[9] is bit 12 of the word; it has priority and means a rotate by 1
    always_comb begin
        rot_n = '0;
        for (int i = 0; i < ROT_STEPS; i++) begin
            if (sel[i]) begin
                rot_n = '0;
                rot_n[ROT_STEPS - 1 - i] = 1'b1;
            end
        end
    end

    // a shift by the full width gives zero, so rot_n of 0 leaves r2 as is
    assign rot_r_vec = (r2 >> rot_n) | (r2 << (`HDC_VEC_W - rot_n));
    assign rot_l_vec = (r2 << rot_n) | (r2 >> (`HDC_VEC_W - rot_n));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r1          <= '0;
            r2          <= '0;
            store       <= 1'b0;
            last        <= 1'b0;
            core_result <= '0;
        end else if (!run) begin
            // leaving run mode wipes the registers
            r1          <= '0;
            r2          <= '0;
            store       <= 1'b0;
            last        <= 1'b0;
            core_result <= '0;
        end else if (exec) begin
            // store and last pulse for one cycle unless this op raises them again
            store       <= 1'b0;
            last        <= 1'b0;
            core_result <= '0;

            if (is_addr) begin
                // write-back never gets here, decoder turns it into a nop
                if (is_load) begin
                    r2 <= ld_vec;
                end
            end else if (rot_r) begin
                r2 <= rot_r_vec;
            end else if (rot_l) begin
                r2 <= rot_l_vec;
            end else if (sel[9]) begin
                r2 <= r1 ^ r2;
            end else if (sel[8]) begin
                store       <= 1'b1;
                core_result <= r2;
            end else if (sel[7]) begin
                last <= 1'b1;
            end else if (sel[6]) begin
                r1 <= r2;
            end else if (sel[5]) begin
                r2 <= sign_bit;
            end
        end else begin
            // a dropped op leaves the outputs idle
            store       <= 1'b0;
            last        <= 1'b0;
            core_result <= '0;
        end
    end

    a_store_last_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(store && last)
    );

endmodule

//--- test/tb_hdc_core.sv
`include "hdc_defs.svh"

module tb_hdc_core
    import hdc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // op view select bits, one-hot in the word
    localparam logic [15:0] OP_NOP   = 16'h0000;
    localparam logic [15:0] OP_XOR   = 16'h1000;
    localparam logic [15:0] OP_STORE = 16'h0800;
    localparam logic [15:0] OP_LAST  = 16'h0400;
    localparam logic [15:0] OP_MOVE  = 16'h0200;
    localparam logic [15:0] OP_SIGN  = 16'h0100;

    // one table row, one instruction slot
    typedef struct packed {
        logic [3:0] test;
        hdc_inst_u  inst;
        logic       get_v;
        logic       exec;
        logic       run;
        logic       fill;
        item_addr_t fill_a;
        hv_t        fill_v;
        logic       exp_store;
        logic       exp_last;
    } entry_t;

    logic       clk;
    logic       arst_n;
    logic       run;
    logic       gen;
    logic       update_item;
    item_addr_t item_a;
    hv_t        rand_num;
    logic       get_v;
    hdc_inst_u  get_d;
    logic       exec;
    hv_t        sign_bit;
    logic       store;
    logic       last;
    hv_t        core_result;

    entry_t tbl[$];
    int     seed = 22;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     test_errs [1:6];
    string  test_name [1:6];
    int     cycles = 0;
    int     cycle_limit = 0;

    // reference state
    hv_t m_r1;
    hv_t m_r2;
    hv_t m_mem [`HDC_DEPTH];
    hv_t sign_vec;

    hdc_core hdc_core_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .gen         (gen),
        .update_item (update_item),
        .item_a      (item_a),
        .rand_num    (rand_num),
        .get_v       (get_v),
        .get_d       (get_d),
        .exec        (exec),
        .sign_bit    (sign_bit),
        .store       (store),
        .last        (last),
        .core_result (core_result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, table never finished", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic hv_t rand_hv();
        hv_t v;
        for (int i = 0; i < `HDC_VEC_W / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    function automatic hv_t right_rotated(input hv_t v, input int n);
        hv_t r;
        for (int i = 0; i < `HDC_VEC_W; i++) begin
            r[i] = v[(i + n) % `HDC_VEC_W];
        end
        return r;
    endfunction

    function automatic hv_t left_rotated(input hv_t v, input int n);
        hv_t r;
        for (int i = 0; i < `HDC_VEC_W; i++) begin
            r[(i + n) % `HDC_VEC_W] = v[i];
        end
        return r;
    endfunction

    // bit 12 means 1, bit 3 means 512, bit 12 wins
    function automatic int shift_amount(input logic [15:0] w);
        int amt;
        amt = 0;
        for (int b = 3; b <= 12; b++) begin
            if (w[b]) amt = 1 << (12 - b);
        end
        return amt;
    endfunction

    function automatic logic [15:0] ld_word(input item_addr_t a);
        return {2'b11, 4'b0000, a};
    endfunction

    function automatic logic [15:0] wb_word(input item_addr_t a);
        return {3'b101, 3'b000, a};
    endfunction

    function automatic logic [15:0] rr_word(input int k);
        return 16'h4000 | (16'h1000 >> k);
    endfunction

    function automatic logic [15:0] rl_word(input int k);
        return 16'h2000 | (16'h1000 >> k);
    endfunction

    task automatic op_entry(input int t, input logic [15:0] w, input logic es = 1'b0,
                            input logic ex = 1'b1, input logic el = 1'b0);
        entry_t e;
        e = '0;
        e.test = 4'(t);
        e.inst = w;
        e.get_v = 1'b1;
        e.exec = ex;
        e.run = 1'b1;
        e.exp_store = es;
        e.exp_last = el;
        tbl.push_back(e);
    endtask

    task automatic fill_entry(input int t, input item_addr_t a);
        entry_t e;
        e = '0;
        e.test = 4'(t);
        e.exec = 1'b1;
        e.run = 1'b1;
        e.fill = 1'b1;
        e.fill_a = a;
        e.fill_v = rand_hv();
        tbl.push_back(e);
    endtask

    task automatic idle_entry(input int t, input logic rn);
        entry_t e;
        e = '0;
        e.test = 4'(t);
        e.exec = 1'b1;
        e.run = rn;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        item_addr_t addrs [4];
        addrs = '{10'd3, 10'd100, 10'd511, 10'd1023};
        foreach (addrs[i]) fill_entry(1, addrs[i]);
        foreach (addrs[i]) begin
            op_entry(1, ld_word(addrs[i]));
            op_entry(1, OP_STORE, 1'b1);
        end
        for (int k = 0; k < 10; k++) begin
            op_entry(2, ld_word(addrs[k % 4]));
            op_entry(2, rr_word(k));
            op_entry(2, OP_STORE, 1'b1);
            op_entry(2, ld_word(addrs[(k + 1) % 4]));
            op_entry(2, rl_word(k));
            op_entry(2, OP_STORE, 1'b1);
        end
        op_entry(3, ld_word(addrs[0]));
        op_entry(3, OP_MOVE);
        op_entry(3, ld_word(addrs[1]));
        op_entry(3, OP_XOR);
        op_entry(3, OP_STORE, 1'b1);
        // r2 differs from every stored entry before the write-back
        op_entry(4, ld_word(addrs[2]));
        op_entry(4, rr_word(0));
        op_entry(4, wb_word(addrs[0]));
        op_entry(4, ld_word(addrs[0]));
        op_entry(4, OP_STORE, 1'b1);
        op_entry(4, ld_word(addrs[1]));
        op_entry(4, ld_word(addrs[0]));
        op_entry(4, OP_STORE, 1'b1);
        op_entry(5, OP_SIGN);
        op_entry(5, OP_STORE, 1'b1);
        op_entry(5, ld_word(addrs[3]));
        op_entry(5, OP_STORE, 1'b0, 1'b0);
        op_entry(5, OP_STORE, 1'b1);
        op_entry(6, OP_LAST, 1'b0, 1'b1, 1'b1);
        op_entry(6, OP_NOP);
        op_entry(6, ld_word(addrs[1]));
        idle_entry(6, 1'b0);
        op_entry(6, OP_STORE, 1'b1);
    endtask

    // in-order model, the pipeline gives the same result for this table
    task automatic model_step(input entry_t e, output hv_t exp_res);
        logic [15:0] w;
        w = e.inst;
        exp_res = '0;
        if (e.fill) m_mem[e.fill_a] = e.fill_v;
        if (!e.run) begin
            m_r1 = '0;
            m_r2 = '0;
        end else if (e.get_v && w[15] && w[13]) begin
            m_mem[w[9:0]] = m_r2;
        end else if (e.get_v && e.exec) begin
            if (w[15]) begin
                if (w[14]) m_r2 = m_mem[w[9:0]];
            end else if (w[14]) begin
                m_r2 = right_rotated(m_r2, shift_amount(w));
            end else if (w[13]) begin
                m_r2 = left_rotated(m_r2, shift_amount(w));
            end else if (w[12]) begin
                m_r2 = m_r1 ^ m_r2;
            end else if (w[11]) begin
                exp_res = m_r2;
            end else if (w[9]) begin
                m_r1 = m_r2;
            end else if (w[8]) begin
                m_r2 = sign_vec;
            end
        end
    endtask

    task automatic hv_compare(input string name, input hv_t got, input hv_t exp, input int t);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errs[t]++;
        end
    endtask

    task automatic bit_compare(input string name, input logic got, input logic exp,
                               input int t);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
            test_errs[t]++;
        end
    endtask

    // exec and run belong to the slot accepted one edge earlier
    task automatic drive_cycle(input int c);
        entry_t cur;
        entry_t prev;
        cur = '0;
        prev = '0;
        prev.run = 1'b1;
        if (c < tbl.size()) cur = tbl[c];
        if (c >= 1 && c - 1 < tbl.size()) prev = tbl[c - 1];
        get_v       <= cur.get_v;
        get_d       <= cur.inst;
        gen         <= cur.fill;
        update_item <= cur.fill;
        item_a      <= cur.fill_a;
        rand_num    <= cur.fill_v;
        exec        <= prev.exec;
        run         <= prev.run;
    endtask

    task automatic check_entry(input int idx);
        entry_t e;
        hv_t    exp_res;
        int     t;
        e = tbl[idx];
        t = int'(e.test);
        model_step(e, exp_res);
        bit_compare("store", store, e.exp_store, t);
        bit_compare("last", last, e.exp_last, t);
        hv_compare("core_result", core_result, exp_res, t);
        if (idx == tbl.size() - 1 || tbl[idx + 1].test != e.test) begin
            if (test_errs[t] == 0) begin
                $display("test %0d (%s): ok", t, test_name[t]);
                tests_passed++;
            end else begin
                $display("test %0d (%s): %0d errors", t, test_name[t], test_errs[t]);
                tests_failed++;
            end
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        run         = 1'b1;
        gen         = 1'b0;
        update_item = 1'b0;
        item_a      = '0;
        rand_num    = '0;
        get_v       = 1'b0;
        get_d       = '0;
        exec        = 1'b0;
        m_r1        = '0;
        m_r2        = '0;
        test_name   = '{"random fill", "rotations", "xor and move",
                        "write-back forwarding", "sign-load and exec low", "last and run"};
        test_errs   = '{0, 0, 0, 0, 0, 0};
        sign_vec    = rand_hv();
        sign_bit    = sign_vec;
        build_table();
        cycle_limit = tbl.size() * 4 + 100;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        // outputs at the falling edge show the slot executed two edges after drive
        for (int c = 0; c < tbl.size() + 2; c++) begin
            @(posedge clk);
            drive_cycle(c);
            @(negedge clk);
            if (c >= 2) check_entry(c - 2);
        end
        $display("tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/hdc_pkg.sv
design/hdc_item_memory.sv
design/hdc_inst_decoder.sv
design/hdc_vector_unit.sv
design/hdc_core.sv
test/tb_hdc_core.sv
